// ==== logic/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////

// Bus widths
`define CACHE_ADDR_BITS 32
`define CACHE_WORD_BITS 32
`define CACHE_SEL_BITS 4

// One line is four CPU words
`define CACHE_LINE_BITS 128
`define CACHE_WORD_SEL_BITS 2

// Associativity and depth
`define CACHE_WAYS 4
`define CACHE_SETS 4

// Address split: tag | index | offset
`define CACHE_OFFSET_BITS 4
`define CACHE_INDEX_BITS 2
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

`endif

// ==== logic/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

	////////////////////////////////////////////////////////////
	// Address and bus types
	////////////////////////////////////////////////////////////

	// CPU byte address split into its cache fields
	typedef struct packed {
		logic [`CACHE_TAG_BITS-1:0] tag;
		logic [`CACHE_INDEX_BITS-1:0] index;
		logic [`CACHE_OFFSET_BITS-1:0] offset;
	} addr_t;

	// Wishbone slave inputs from the CPU
	typedef struct packed {
		addr_t adr;
		logic we;
		logic [`CACHE_SEL_BITS-1:0] sel;
		logic [`CACHE_WORD_BITS-1:0] dat;
		logic cyc;
		logic stb;
	} cpu_req_t;

	// Wishbone master outputs toward memory, one line per transfer
	typedef struct packed {
		logic [`CACHE_ADDR_BITS-1:0] adr;
		logic we;
		logic [`CACHE_LINE_BITS-1:0] dat;
		logic cyc;
		logic stb;
	} mem_req_t;

	// One bit per way
	typedef logic [`CACHE_WAYS-1:0] way_sel_t;

	////////////////////////////////////////////////////////////
	// Controller
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITE_BACK,
		REFILL,
		DONE
	} ctrl_state_t;

endpackage

// ==== logic/cache_ways.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_ways (
	input logic clk,
	input logic reset,
	input logic [`CACHE_INDEX_BITS-1:0] index,
	input logic [`CACHE_TAG_BITS-1:0] tag,
	input logic wr_en,
	input logic fill_en,
	input cache_pkg::way_sel_t way,
	input logic [`CACHE_WORD_SEL_BITS-1:0] word_sel,
	input logic [`CACHE_SEL_BITS-1:0] byte_mask,
	input logic [`CACHE_WORD_BITS-1:0] wr_word,
	input logic [`CACHE_LINE_BITS-1:0] fill_line,
	output cache_pkg::way_sel_t hit_way,
	output logic [`CACHE_WAYS-1:0] valid_ways,
	output logic [`CACHE_WORD_BITS-1:0] rd_word,
	output logic [`CACHE_TAG_BITS-1:0] victim_tag,
	output logic victim_valid,
	output logic victim_dirty,
	output logic [`CACHE_LINE_BITS-1:0] victim_line
);

	localparam int WAY_BITS = $clog2(`CACHE_WAYS);

	logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_LINE_BITS-1:0] lines [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid;
	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty;
	logic [WAY_BITS-1:0] way_idx;
	logic [`CACHE_LINE_BITS-1:0] sel_line;
	logic [`CACHE_WORD_BITS-1:0] merged;

	function automatic logic [WAY_BITS-1:0] onehot_to_idx(input logic [`CACHE_WAYS-1:0] oh);
		logic [WAY_BITS-1:0] idx;
		idx = '0;
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			if (oh[i])
				idx = idx | WAY_BITS'(i);
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////

	// All four tags compared at once
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			valid_ways[w] = valid[w][index];
			hit_way[w] = valid[w][index] && (tags[w][index] == tag);
		end
	end

	assign way_idx = onehot_to_idx(way);
	assign sel_line = lines[way_idx][index];
	assign rd_word = sel_line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];

	// Same way serves as victim during a miss
	assign victim_line = sel_line;
	assign victim_tag = tags[way_idx][index];
	assign victim_valid = valid[way_idx][index];
	assign victim_dirty = dirty[way_idx][index];

	// Byte merge against the stored word
	always_comb begin
		for (int b = 0; b < `CACHE_SEL_BITS; b++) begin
			merged[8*b +: 8] = byte_mask[b] ? wr_word[8*b +: 8] : rd_word[8*b +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// Update
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[way_idx][index] <= fill_line;
			tags[way_idx][index] <= tag;
		end else if (wr_en) begin
			lines[way_idx][index][word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] <= merged;
		end
	end

	// Fill leaves a clean line, a write marks it dirty
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (fill_en) begin
			valid[way_idx][index] <= 1'b1;
			dirty[way_idx][index] <= 1'b0;
		end else if (wr_en) begin
			dirty[way_idx][index] <= 1'b1;
		end
	end

endmodule

// ==== logic/plru_tree.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module plru_tree (
	input logic clk,
	input logic reset,
	input logic touch,
	input logic [`CACHE_INDEX_BITS-1:0] index,
	input cache_pkg::way_sel_t touch_way,
	input logic [`CACHE_WAYS-1:0] valid_ways,
	output cache_pkg::way_sel_t victim
);

	// Bit 2 is the root, bit 1 picks in ways 0/1, bit 0 picks in ways 2/3
	logic [`CACHE_SETS-1:0][2:0] tree;
	logic [2:0] cur;

	assign cur = tree[index];

	// Touched path is pointed away from
	always_ff @(posedge clk) begin
		if (reset) begin
			tree <= '0;
		end else if (touch) begin
			case (touch_way)
				4'b0001: tree[index] <= {2'b11, cur[0]};
				4'b0010: tree[index] <= {2'b10, cur[0]};
				4'b0100: tree[index] <= {1'b0, cur[1], 1'b1};
				4'b1000: tree[index] <= {1'b0, cur[1], 1'b0};
				default: tree[index] <= cur;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Victim choice
	////////////////////////////////////////////////////////////

	always_comb begin
		victim = '0;
		if (!(&valid_ways)) begin
			// Walk down so the lowest invalid way is kept
			for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
				if (!valid_ways[w]) begin
					victim = '0;
					victim[w] = 1'b1;
				end
			end
		end else if (!cur[2]) begin
			victim[{1'b0, cur[1]}] = 1'b1;
		end else begin
			victim[{1'b1, cur[0]}] = 1'b1;
		end
	end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_ctrl (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	output logic cpu_ack,
	output logic [`CACHE_WORD_BITS-1:0] cpu_dat,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_ack,
	input logic [`CACHE_LINE_BITS-1:0] mem_dat,
	// Way storage side
	output logic [`CACHE_INDEX_BITS-1:0] index,
	output logic [`CACHE_TAG_BITS-1:0] tag,
	output logic wr_en,
	output logic [`CACHE_WORD_SEL_BITS-1:0] word_sel,
	output logic [`CACHE_SEL_BITS-1:0] byte_mask,
	output logic [`CACHE_WORD_BITS-1:0] wr_word,
	output logic fill_en,
	output logic [`CACHE_LINE_BITS-1:0] fill_line,
	output cache_pkg::way_sel_t way,
	input cache_pkg::way_sel_t hit_way,
	input logic [`CACHE_WORD_BITS-1:0] rd_word,
	input logic [`CACHE_TAG_BITS-1:0] victim_tag,
	input logic victim_valid,
	input logic victim_dirty,
	input logic [`CACHE_LINE_BITS-1:0] victim_line,
	// Replacement side
	output logic touch,
	output cache_pkg::way_sel_t touch_way,
	input cache_pkg::way_sel_t victim
);

	import cache_pkg::*;

	ctrl_state_t state;
	cpu_req_t req_q;
	way_sel_t way_q;
	logic hit;
	logic accept;
	logic miss;
	logic wb_start;
	logic rd_start;
	logic mem_busy;
	logic mem_we;
	logic [`CACHE_ADDR_BITS-1:0] mem_adr;
	logic [`CACHE_LINE_BITS-1:0] mem_line;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	assign hit = |hit_way;
	assign accept = (state == IDLE) && cpu_req.cyc && cpu_req.stb;
	assign miss = (state == LOOKUP) && !hit;
	assign wb_start = miss && victim_valid && victim_dirty;
	// Read goes out one cycle after a write-back ack drops stb
	assign rd_start = (state == REFILL) && !mem_busy;

	// Latched request drives the ways
	assign index = req_q.adr.index;
	assign tag = req_q.adr.tag;
	assign word_sel = req_q.adr.offset[`CACHE_OFFSET_BITS-1 -: `CACHE_WORD_SEL_BITS];
	assign byte_mask = req_q.sel;
	assign wr_word = req_q.dat;
	assign fill_line = mem_dat;

	// Hit way in lookup, else the victim so its status is visible
	assign way = (state == LOOKUP) ? (hit ? hit_way : victim) : way_q;

	assign touch = (state == LOOKUP) && hit;
	assign touch_way = hit_way;
	assign wr_en = touch && req_q.we;
	assign fill_en = (state == REFILL) && mem_busy && mem_ack;

	assign mem_req = '{adr: mem_adr, we: mem_we, dat: mem_line, cyc: mem_busy, stb: mem_busy};

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cpu_ack <= 1'b0;
			mem_busy <= 1'b0;
		end else begin
			// One-cycle ack after a hit
			cpu_ack <= touch;

			if (wb_start || rd_start)
				mem_busy <= 1'b1;
			else if (mem_busy && mem_ack)
				mem_busy <= 1'b0;

			case (state)
				IDLE: begin
					if (accept)
						state <= LOOKUP;
				end
				LOOKUP: begin
					if (hit)
						state <= DONE;
					else if (wb_start)
						state <= WRITE_BACK;
					else
						state <= REFILL;
				end
				WRITE_BACK: begin
					if (mem_ack)
						state <= REFILL;
				end
				REFILL: begin
					// Back to lookup, which now hits
					if (fill_en)
						state <= LOOKUP;
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Request, read data and memory payload
	always_ff @(posedge clk) begin
		if (accept)
			req_q <= cpu_req;
		if (touch)
			cpu_dat <= rd_word;
		if (miss)
			way_q <= victim;
		if (wb_start) begin
			mem_adr <= {victim_tag, index, {`CACHE_OFFSET_BITS{1'b0}}};
			mem_we <= 1'b1;
			mem_line <= victim_line;
		end else if (rd_start) begin
			mem_adr <= {tag, index, {`CACHE_OFFSET_BITS{1'b0}}};
			mem_we <= 1'b0;
		end
	end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_top (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	output logic cpu_ack,
	output logic [`CACHE_WORD_BITS-1:0] cpu_dat,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_ack,
	input logic [`CACHE_LINE_BITS-1:0] mem_dat
);

	import cache_pkg::*;

	////////////////////////////////////////////////////////////
	// Controller to ways
	////////////////////////////////////////////////////////////

	logic [`CACHE_INDEX_BITS-1:0] index;
	logic [`CACHE_TAG_BITS-1:0] tag;
	logic wr_en;
	logic fill_en;
	way_sel_t way;
	logic [`CACHE_WORD_SEL_BITS-1:0] word_sel;
	logic [`CACHE_SEL_BITS-1:0] byte_mask;
	logic [`CACHE_WORD_BITS-1:0] wr_word;
	logic [`CACHE_LINE_BITS-1:0] fill_line;

	// Ways back to controller
	way_sel_t hit_way;
	logic [`CACHE_WAYS-1:0] valid_ways;
	logic [`CACHE_WORD_BITS-1:0] rd_word;
	logic [`CACHE_TAG_BITS-1:0] victim_tag;
	logic victim_valid;
	logic victim_dirty;
	logic [`CACHE_LINE_BITS-1:0] victim_line;

	// Replacement
	logic touch;
	way_sel_t touch_way;
	way_sel_t victim;

	cache_ctrl u_ctrl (
		.clk(clk), .reset(reset),
		.cpu_req(cpu_req), .cpu_ack(cpu_ack), .cpu_dat(cpu_dat),
		.mem_req(mem_req), .mem_ack(mem_ack), .mem_dat(mem_dat),
		.index(index), .tag(tag), .wr_en(wr_en), .word_sel(word_sel),
		.byte_mask(byte_mask), .wr_word(wr_word), .fill_en(fill_en),
		.fill_line(fill_line), .way(way), .hit_way(hit_way), .rd_word(rd_word),
		.victim_tag(victim_tag), .victim_valid(victim_valid),
		.victim_dirty(victim_dirty), .victim_line(victim_line),
		.touch(touch), .touch_way(touch_way), .victim(victim)
	);

	cache_ways u_ways (
		.clk(clk), .reset(reset), .index(index), .tag(tag),
		.wr_en(wr_en), .fill_en(fill_en), .way(way), .word_sel(word_sel),
		.byte_mask(byte_mask), .wr_word(wr_word), .fill_line(fill_line),
		.hit_way(hit_way), .valid_ways(valid_ways), .rd_word(rd_word),
		.victim_tag(victim_tag), .victim_valid(victim_valid),
		.victim_dirty(victim_dirty), .victim_line(victim_line)
	);

	plru_tree u_plru (
		.clk(clk), .reset(reset), .touch(touch), .index(index),
		.touch_way(touch_way), .valid_ways(valid_ways), .victim(victim)
	);

endmodule

// ==== test/cache_mem_model.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_mem_model (
	input logic clk,
	input logic reset,
	input cache_pkg::mem_req_t mem_req,
	output logic mem_ack,
	output logic [`CACHE_LINE_BITS-1:0] mem_dat,
	output int wr_count,
	output int rd_count
);

	// 64 lines of four words
	logic [31:0] mem [256];
	integer seed;
	int delay;
	int wait_cnt;
	int base;

	initial begin
		seed = 32'h808;
		delay = 0;
		mem_ack = 1'b0;
		mem_dat = '0;
		for (int w = 0; w < 256; w++)
			mem[w] = w * 32'h9E3779B1;
	end

	// Registered ack after 0 to 7 wait cycles
	always @(posedge clk) begin
		if (reset) begin
			mem_ack <= 1'b0;
			wait_cnt <= 0;
			wr_count <= 0;
			rd_count <= 0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
		end else if (mem_req.cyc && mem_req.stb) begin
			if (wait_cnt < delay) begin
				wait_cnt <= wait_cnt + 1;
			end else begin
				base = mem_req.adr[9:4] * 4;
				mem_ack <= 1'b1;
				wait_cnt <= 0;
				delay <= {$random(seed)} % 8;
				if (mem_req.we) begin
					// Write-back log
					wr_count <= wr_count + 1;
					for (int i = 0; i < 4; i++)
						mem[base + i] <= mem_req.dat[32*i +: 32];
				end else begin
					rd_count <= rd_count + 1;
					for (int i = 0; i < 4; i++)
						mem_dat[32*i +: 32] <= mem[base + i];
				end
			end
		end
	end

endmodule

// ==== test/cache_assert.sv ====
`timescale 1ns/1ps

module cache_assert (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	input logic cpu_ack,
	input cache_pkg::mem_req_t mem_req,
	input logic mem_ack
);

	// Number of failed properties
	int failures = 0;

	////////////////////////////////////////////////////////////
	// CPU port
	////////////////////////////////////////////////////////////

	cpu_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		cpu_ack |=> !cpu_ack)
		else begin
			failures++;
			$error("cpu_ack held for more than one cycle");
		end

	cpu_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		cpu_ack |-> cpu_req.cyc && cpu_req.stb)
		else begin
			failures++;
			$error("cpu_ack outside a CPU bus cycle");
		end

	////////////////////////////////////////////////////////////
	// Memory port
	////////////////////////////////////////////////////////////

	mem_stb_held: assert property (@(posedge clk) disable iff (reset)
		mem_req.stb && !mem_ack |=> mem_req.stb && $stable(mem_req.adr) && $stable(mem_req.we))
		else begin
			failures++;
			$error("Memory request changed before mem_ack");
		end

	mem_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		mem_ack |-> mem_req.cyc && mem_req.stb)
		else begin
			failures++;
			$error("mem_ack outside a memory bus cycle");
		end

	mem_stb_drop: assert property (@(posedge clk) disable iff (reset)
		mem_ack |=> !mem_req.stb)
		else begin
			failures++;
			$error("Memory stb still high after mem_ack");
		end

endmodule

bind cache_top cache_assert u_assert (
	.clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_ack(cpu_ack),
	.mem_req(mem_req), .mem_ack(mem_ack)
);

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_tb;

	import cache_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_REQ = 600;
	localparam int REQ_CYCLES = 40;
	localparam int WATCHDOG_NS = NUM_REQ * REQ_CYCLES * CLK_PERIOD;
	// Negedges from the drive edge up to a hit's ack
	localparam int HIT_LATENCY = 3;

	logic clk;
	logic reset;
	cpu_req_t cpu_req;
	logic cpu_ack;
	logic [`CACHE_WORD_BITS-1:0] cpu_dat;
	mem_req_t mem_req;
	logic mem_ack;
	logic [`CACHE_LINE_BITS-1:0] mem_dat;
	int mem_writes;
	int mem_reads;

	// Reference memory, tag directory (bit per way) and PLRU trees
	logic [31:0] ref_mem [256];
	logic [`CACHE_TAG_BITS-1:0] dir_tag [4][4];
	logic [3:0] dir_valid [4];
	logic [3:0] dir_dirty [4];
	logic [2:0] tree [4];
	integer seed;
	int errors;
	int checks;
	int requests;
	int exp_writes;
	int exp_reads;
	logic aborted;

	// Memory transfers seen during the current request
	logic xfer_we [4];
	logic [31:0] xfer_adr [4];
	logic [`CACHE_LINE_BITS-1:0] xfer_dat [4];
	int xfer_n;

	cache_top uut (
		.clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_ack(cpu_ack), .cpu_dat(cpu_dat),
		.mem_req(mem_req), .mem_ack(mem_ack), .mem_dat(mem_dat)
	);

	cache_mem_model u_mem (
		.clk(clk), .reset(reset), .mem_req(mem_req), .mem_ack(mem_ack), .mem_dat(mem_dat),
		.wr_count(mem_writes), .rd_count(mem_reads)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	always @(negedge clk) begin
		if (!reset && mem_ack && mem_req.cyc && mem_req.stb) begin
			if (xfer_n < 4) begin
				xfer_we[xfer_n] = mem_req.we;
				xfer_adr[xfer_n] = mem_req.adr;
				xfer_dat[xfer_n] = mem_req.dat;
			end
			xfer_n++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		$display("FAIL %s: got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s (at %0t)", msg, $time);
		errors++;
	endtask

	// Lowest invalid way first, then follow the tree
	function automatic int choose_victim(input int set);
		for (int w = 0; w < 4; w++)
			if (!dir_valid[set][w])
				return w;
		if (!tree[set][2])
			return tree[set][1] ? 1 : 0;
		return tree[set][0] ? 3 : 2;
	endfunction

	// Root and leaf point away from the touched way
	task automatic touch_tree(input int set, input int way);
		if (way < 2) begin
			tree[set][2] = 1'b1;
			tree[set][1] = (way == 0);
		end else begin
			tree[set][2] = 1'b0;
			tree[set][0] = (way == 2);
		end
	endtask

	////////////////////////////////////////////////////////////
	// One CPU request, predicted and checked
	////////////////////////////////////////////////////////////

	task automatic run_request(input int tg, input int set, input int wd, input logic we,
			input logic [3:0] sel, input logic [31:0] dat);
		cpu_req_t req;
		int hit;
		int way;
		int n;
		int base;
		logic ack_seen;
		logic wb_expected;
		logic [31:0] line_adr;
		logic [31:0] wb_adr;
		logic [127:0] wb_line;
		logic [31:0] exp_word;
		hit = -1;
		wb_expected = 1'b0;
		wb_adr = '0;
		wb_line = '0;
		for (int w = 0; w < 4; w++)
			if (dir_valid[set][w] && dir_tag[w][set] == tg)
				hit = w;
		line_adr = 32'((tg * 4 + set) * 16);
		base = (tg * 4 + set) * 4;
		exp_word = ref_mem[base + wd];
		way = (hit >= 0) ? hit : choose_victim(set);
		if (hit < 0 && dir_valid[set][way] && dir_dirty[set][way]) begin
			wb_expected = 1'b1;
			wb_adr = 32'(dir_tag[way][set]) * 64 + 32'(set * 16);
			for (int i = 0; i < 4; i++)
				wb_line[32*i +: 32] = ref_mem[wb_adr / 4 + i];
		end

		req = '0;
		req.adr = addr_t'(line_adr + 32'(wd * 4));
		req.we = we;
		req.sel = sel;
		req.dat = dat;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		@(posedge clk);
		xfer_n = 0;
		cpu_req <= req;
		n = 0;
		ack_seen = 1'b0;
		while (!ack_seen && n < REQ_CYCLES) begin
			@(negedge clk);
			n++;
			ack_seen = cpu_ack;
		end
		if (!ack_seen) begin
			report_problem($sformatf("No cpu_ack within %0d cycles for address %h",
				REQ_CYCLES, req.adr));
			aborted = 1'b1;
			return;
		end

		checks++;
		if (hit >= 0) begin
			if (n != HIT_LATENCY)
				report_problem($sformatf("Hit at %h took %0d cycles instead of %0d",
					req.adr, n, HIT_LATENCY));
			if (xfer_n != 0)
				report_problem($sformatf("Hit at %h caused a memory transfer", req.adr));
		end else if (wb_expected) begin
			exp_writes++;
			exp_reads++;
			if (xfer_n != 2) begin
				report_problem($sformatf("Dirty miss at %h made %0d transfers instead of 2",
					req.adr, xfer_n));
			end else begin
				if (xfer_we[0] !== 1'b1 || xfer_we[1] !== 1'b0)
					report_problem("Write-back did not come before the refill read");
				if (xfer_adr[0] !== wb_adr)
					report_mismatch("mem_req.adr (write-back)", xfer_adr[0], wb_adr);
				if (xfer_dat[0] !== wb_line)
					report_mismatch("mem_req.dat (write-back)", xfer_dat[0], wb_line);
				if (xfer_adr[1] !== line_adr)
					report_mismatch("mem_req.adr (refill)", xfer_adr[1], line_adr);
			end
		end else begin
			exp_reads++;
			if (xfer_n != 1) begin
				report_problem($sformatf("Clean miss at %h made %0d transfers instead of 1",
					req.adr, xfer_n));
			end else begin
				if (xfer_we[0] !== 1'b0)
					report_problem($sformatf("Clean miss at %h wrote to memory", req.adr));
				if (xfer_adr[0] !== line_adr)
					report_mismatch("mem_req.adr (refill)", xfer_adr[0], line_adr);
			end
		end
		if (!we && cpu_dat !== exp_word)
			report_mismatch("cpu_dat", cpu_dat, exp_word);

		// Fill on a miss, then the final lookup touches and writes
		if (hit < 0) begin
			dir_tag[way][set] = tg;
			dir_valid[set][way] = 1'b1;
			dir_dirty[set][way] = 1'b0;
		end
		touch_tree(set, way);
		if (we) begin
			dir_dirty[set][way] = 1'b1;
			for (int b = 0; b < 4; b++)
				if (sel[b])
					ref_mem[base + wd][8*b +: 8] = dat[8*b +: 8];
		end
		@(posedge clk);
		cpu_req <= '0;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin : main
		int tg;
		int set;
		int wd;
		logic we;
		logic [3:0] sel;
		logic [31:0] dat;
		clk = 1'b0;
		seed = 32'h808;
		errors = 0;
		checks = 0;
		requests = 0;
		exp_writes = 0;
		exp_reads = 0;
		aborted = 1'b0;
		xfer_n = 0;
		for (int w = 0; w < 256; w++)
			ref_mem[w] = w * 32'h9E3779B1;
		for (int s = 0; s < 4; s++) begin
			dir_valid[s] = '0;
			dir_dirty[s] = '0;
			tree[s] = '0;
		end
		reset <= 1'b1;
		cpu_req <= '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Both bus ports idle once reset is released
		@(negedge clk);
		if (cpu_ack !== 1'b0)
			report_mismatch("cpu_ack", cpu_ack, 128'h0);
		if (mem_req.cyc !== 1'b0)
			report_mismatch("mem_req.cyc", mem_req.cyc, 128'h0);
		if (mem_req.stb !== 1'b0)
			report_mismatch("mem_req.stb", mem_req.stb, 128'h0);

		// 16 tags over 4 sets keeps evictions frequent
		for (int r = 0; r < NUM_REQ && !aborted; r++) begin
			tg = {$random(seed)} % 16;
			set = {$random(seed)} % 4;
			wd = {$random(seed)} % 4;
			we = $random(seed);
			sel = $random(seed);
			if (sel == 4'b0000)
				sel = 4'b1111;
			dat = $random(seed);
			run_request(tg, set, wd, we, sel, dat);
			requests++;
			repeat ({$random(seed)} % 3) @(posedge clk);
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		if (mem_writes != exp_writes)
			report_mismatch("mem write count", mem_writes, exp_writes);
		if (mem_reads != exp_reads)
			report_mismatch("mem read count", mem_reads, exp_reads);
		if (uut.u_assert.failures != 0)
			report_problem($sformatf("%0d bus protocol assertions failed",
				uut.u_assert.failures));
		$display("Requests %0d, checks %0d, errors %0d", requests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+logic
logic/cache_pkg.sv
logic/cache_ways.sv
logic/plru_tree.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/cache_mem_model.sv
test/cache_assert.sv
test/cache_tb.sv
